//--- common/bypass_config.svh
`ifndef BYPASS_CONFIG_SVH
`define BYPASS_CONFIG_SVH

// Build-time sizing for the operand bypass and hazard-stall unit

// Number of register file read ports that the decoder presents in ID
// Operand A is port 0 and operand B is port 1
`define BYP_NUM_READ_PORTS 2

// Width of a register file address, which gives 32 integer registers
`define BYP_RF_ADDR_W 5

// The jump-register target always comes from read port 0
// This index is fixed by the RISC-V encoding of rs1

`endif

//--- common/pipe_pkg.sv
`default_nettype none

`include "bypass_config.svh"

// Types for what the pipeline hands to the bypass unit
package pipe_pkg;

  // One register file address
  typedef logic [`BYP_RF_ADDR_W-1:0] rf_addr_t;

  // Decoded instruction sitting in ID
  // The fault flags come straight from the fetch path and are not yet folded
  // into any write enable
  typedef struct packed {
    logic                                   instr_valid;
    logic                                   bus_err;
    logic                                   mpu_fault;
    logic     [`BYP_NUM_READ_PORTS-1:0]     rf_re;
    rf_addr_t [`BYP_NUM_READ_PORTS-1:0]     rf_raddr;
    logic                                   alu_jmpr;
    logic                                   csr_en;
    logic                                   sys_mret;
    logic                                   sys_wfi;
  } id_dec_t;

  // Contents of one downstream pipeline register
  // Both the ID/EX and the EX/WB register are described by this type
  typedef struct packed {
    logic     instr_valid;
    logic     rf_we;
    rf_addr_t rf_waddr;
    // Memory access, so the write data arrives late
    logic     lsu_en;
    // Explicit CSR access
    logic     csr_en;
    // System instruction, qualifies the mret and wfi bits below
    logic     sys_en;
    logic     sys_mret_insn;
    logic     sys_wfi_insn;
  } stage_pipe_t;

endpackage

`default_nettype wire

//--- common/bypass_pkg.sv
`default_nettype none

`include "bypass_config.svh"

// Types for what the bypass unit produces, internally and at its outputs
package bypass_pkg;

  // Hazard summary of one downstream stage against the instruction in ID
  typedef struct packed {
    // Qualified write hits, one per read port
    logic [`BYP_NUM_READ_PORTS-1:0] op_hit;
    // Write hit on rs1 without regard to the read enable
    logic                           jalr_hit;
    // Same hits when the stage holds a load
    logic                           load_op_hit;
    logic                           load_jalr_hit;
    // Stage writes a CSR, explicitly or through mret
    logic                           csr_wr_pend;
    // Stage holds a wfi that may put the core to sleep
    logic                           sleep_pend;
  } stage_hit_t;

  // Operand forward mux select
  typedef enum logic [1:0] {
    SEL_REGFILE = 2'b00,
    SEL_FW_EX   = 2'b01,
    SEL_FW_WB   = 2'b10
  } fw_sel_e;

  // Jump-register target mux select, only WB can forward here
  typedef enum logic {
    SELJ_REGFILE = 1'b0,
    SELJ_FW_WB   = 1'b1
  } jalr_sel_e;

  typedef struct packed {
    logic load_stall;
    logic jalr_stall;
    logic csr_stall;
    logic sleep_stall;
    logic deassert_we;
  } stall_t;

  typedef struct packed {
    fw_sel_e   operand_a_fw_mux_sel;
    fw_sel_e   operand_b_fw_mux_sel;
    jalr_sel_e jalr_fw_mux_sel;
  } fwd_t;

  // Everything the controller and ID stage receive from the bypass unit
  typedef struct packed {
    stall_t stall;
    fwd_t   fwd;
  } ctrl_byp_t;

endpackage

`default_nettype wire

//--- source/stage_hazard.sv
`timescale 1ns/1ps
`default_nettype none

`include "bypass_config.svh"

// Compares the ID read addresses against the write of one downstream stage
// The same comparison serves EX and WB; their priority is applied later
module stage_hazard import pipe_pkg::*, bypass_pkg::*; (
  input  id_dec_t     dec_i,
  input  stage_pipe_t stage_i,
  output stage_hit_t  hit_o
);

  // Stage really writes the register file
  logic                           stage_we;
  // Address equality with x0 excluded, not yet qualified by anything else
  logic [`BYP_NUM_READ_PORTS-1:0] addr_match;
  logic [`BYP_NUM_READ_PORTS-1:0] op_hit;
  logic                           jalr_hit;

  assign stage_we = stage_i.instr_valid && stage_i.rf_we;

  ////////////////////////////////////////////////////////////////////////////
  // Address comparators
  ////////////////////////////////////////////////////////////////////////////

  for (genvar p = 0; p < `BYP_NUM_READ_PORTS; p++) begin : gen_port_cmp
    // Reads of x0 always return zero, so they never need a bypass
    assign addr_match[p] = (stage_i.rf_waddr == dec_i.rf_raddr[p]) &&
                           (dec_i.rf_raddr[p] != '0);

    // An operand hit also needs the port to be read at all
    assign op_hit[p] = stage_we && addr_match[p] && dec_i.rf_re[p];
  end

  // The jump-register path looks at rs1 only
  // A jalr always reads rs1, so the read enable is left out here
  assign jalr_hit = stage_we && addr_match[0];

  ////////////////////////////////////////////////////////////////////////////
  // Stage classification
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    hit_o.op_hit   = op_hit;
    hit_o.jalr_hit = jalr_hit;

    // Load data is not available in time to forward, so these cases stall
    hit_o.load_op_hit   = stage_i.lsu_en && (|op_hit);
    hit_o.load_jalr_hit = stage_i.lsu_en && jalr_hit;

    // mret updates mstatus implicitly, which counts as a CSR write
    hit_o.csr_wr_pend = stage_i.instr_valid &&
                        (stage_i.csr_en || (stage_i.sys_en && stage_i.sys_mret_insn));

    // A wfi on its way down may halt the core
    hit_o.sleep_pend = stage_i.instr_valid && stage_i.sys_en && stage_i.sys_wfi_insn;
  end

endmodule

`default_nettype wire

//--- source/stall_control.sv
`timescale 1ns/1ps
`default_nettype none

// Turns the hazard summaries of EX and WB into the ID stall requests
// Also produces the write-enable deassert for faulted instructions
module stall_control import pipe_pkg::*, bypass_pkg::*; (
  input  id_dec_t    dec_i,
  input  stage_hit_t ex_hit_i,
  input  stage_hit_t wb_hit_i,
  input  logic       wb_ready_i,
  output stall_t     stall_o
);

  // Valid jalr in ID
  logic id_jmpr;
  // Valid instruction in ID that reads CSR state
  logic id_csr_read;
  // Load in EX whose result ID needs
  logic ex_load_use;
  // Write in WB that ID needs while WB is still waiting
  logic wb_wait_use;
  // Target of the jalr is not available on the forward path
  logic jalr_unavail;
  // Some CSR write is still in flight below ID
  logic csr_wr_below;

  ////////////////////////////////////////////////////////////////////////////
  // ID qualification
  ////////////////////////////////////////////////////////////////////////////

  // The ID valid bit is applied here and nowhere else
  assign id_jmpr = dec_i.instr_valid && dec_i.alu_jmpr;

  // wfi reads mstatus.tw and the privilege level, mret reads mstatus.mpp,
  // so both are treated like an explicit CSR read
  assign id_csr_read = dec_i.instr_valid &&
                       (dec_i.csr_en || dec_i.sys_mret || dec_i.sys_wfi);

  ////////////////////////////////////////////////////////////////////////////
  // Hazard terms
  ////////////////////////////////////////////////////////////////////////////

  assign ex_load_use = ex_hit_i.load_op_hit;

  // WB forwarding only works once WB has its data, loads included
  assign wb_wait_use = !wb_ready_i && (|wb_hit_i.op_hit);

  // Anything writing rs1 in EX is too late for the jump target path
  // From WB only ALU results can be forwarded, a load must be waited for
  assign jalr_unavail = ex_hit_i.jalr_hit || wb_hit_i.load_jalr_hit;

  assign csr_wr_below = ex_hit_i.csr_wr_pend || wb_hit_i.csr_wr_pend;

  ////////////////////////////////////////////////////////////////////////////
  // Stall outputs
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    stall_o = '0;

    // A fetch fault turns the instruction into a bubble that still flows to
    // WB, where the exception is taken
    // This does not look at the ID valid bit
    if (dec_i.bus_err || dec_i.mpu_fault) begin
      stall_o.deassert_we = 1'b1;
    end

    // Load-use hazard from EX, or any use while WB sits in a wait state
    if (ex_load_use || wb_wait_use) begin
      stall_o.load_stall = 1'b1;
    end

    // ID is held anyway, so nothing needs to be deasserted for jalr
    if (id_jmpr && jalr_unavail) begin
      stall_o.jalr_stall = 1'b1;
    end

    // CSR state is read in ID, so hold it until every write has retired
    if (id_csr_read && csr_wr_below) begin
      stall_o.csr_stall = 1'b1;
    end

    // Keep later instructions, loads and stores in particular, out of EX
    // while a wfi there decides whether to sleep
    if (ex_hit_i.sleep_pend) begin
      stall_o.sleep_stall = 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- source/forward_select.sv
`timescale 1ns/1ps
`default_nettype none

// Picks the source of each ID operand and of the jump target
// EX holds the newer value, so it wins over WB
module forward_select import bypass_pkg::*; (
  input  stage_hit_t ex_hit_i,
  input  stage_hit_t wb_hit_i,
  output fwd_t       fwd_o
);

  ////////////////////////////////////////////////////////////////////////////
  // Operand forwarding
  ////////////////////////////////////////////////////////////////////////////

  // Loads are not filtered out here
  // When EX holds a load the load stall keeps ID from using this select
  always_comb begin
    fwd_o.operand_a_fw_mux_sel = SEL_REGFILE;
    fwd_o.operand_b_fw_mux_sel = SEL_REGFILE;

    // Older result from WB first
    if (wb_hit_i.op_hit[0]) begin
      fwd_o.operand_a_fw_mux_sel = SEL_FW_WB;
    end
    if (wb_hit_i.op_hit[1]) begin
      fwd_o.operand_b_fw_mux_sel = SEL_FW_WB;
    end

    // Newer result from EX overrides it
    if (ex_hit_i.op_hit[0]) begin
      fwd_o.operand_a_fw_mux_sel = SEL_FW_EX;
    end
    if (ex_hit_i.op_hit[1]) begin
      fwd_o.operand_b_fw_mux_sel = SEL_FW_EX;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Jump-register forwarding
  ////////////////////////////////////////////////////////////////////////////

  // Only WB feeds the jump target, to keep the path out of the ALU
  // If EX also writes rs1, or WB holds a load, the jalr stall covers it
  always_comb begin
    if (wb_hit_i.jalr_hit) begin
      fwd_o.jalr_fw_mux_sel = SELJ_FW_WB;
    end else begin
      fwd_o.jalr_fw_mux_sel = SELJ_REGFILE;
    end
  end

endmodule

`default_nettype wire

//--- source/controller_bypass.sv
`timescale 1ns/1ps
`default_nettype none

`include "bypass_config.svh"

// Operand bypass and hazard-stall unit of the ID stage
// Everything here is combinational; there is no clock and no state
module controller_bypass import pipe_pkg::*, bypass_pkg::*; (
  // Decoded instruction in ID
  input  id_dec_t     id_dec_i,
  // ID/EX pipeline register
  input  stage_pipe_t id_ex_pipe_i,
  // EX/WB pipeline register
  input  stage_pipe_t ex_wb_pipe_i,
  // WB has its write data, loads included
  input  logic        wb_ready_i,
  output ctrl_byp_t   ctrl_byp_o
);

  stage_hit_t ex_hit;
  stage_hit_t wb_hit;
  stall_t     stall;
  fwd_t       fwd;

  ////////////////////////////////////////////////////////////////////////////
  // Per-stage hazard detection
  ////////////////////////////////////////////////////////////////////////////

  stage_hazard i_ex_hazard (
    .dec_i   (id_dec_i),
    .stage_i (id_ex_pipe_i),
    .hit_o   (ex_hit)
  );

  stage_hazard i_wb_hazard (
    .dec_i   (id_dec_i),
    .stage_i (ex_wb_pipe_i),
    .hit_o   (wb_hit)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Stall and forward decisions
  ////////////////////////////////////////////////////////////////////////////

  stall_control i_stall_control (
    .dec_i      (id_dec_i),
    .ex_hit_i   (ex_hit),
    .wb_hit_i   (wb_hit),
    .wb_ready_i (wb_ready_i),
    .stall_o    (stall)
  );

  forward_select i_forward_select (
    .ex_hit_i (ex_hit),
    .wb_hit_i (wb_hit),
    .fwd_o    (fwd)
  );

  // Stall group goes in the upper bits, forward selects in the lower bits
  assign ctrl_byp_o = '{stall: stall, fwd: fwd};

endmodule

`default_nettype wire

//--- test/tb_controller_bypass.sv
`timescale 1ns/1ps
`default_nettype none

// Random testbench for the combinational bypass and hazard-stall unit
// The clock only paces stimulus because the DUT itself has no clock
module tb_controller_bypass import pipe_pkg::*, bypass_pkg::*; ();

  localparam int NUM_VECTORS    = 2000;
  localparam int RESET_CYCLES   = 10;
  // Reset with its idle checks and all vectors, plus some margin
  localparam int TIMEOUT_CYCLES = RESET_CYCLES + NUM_VECTORS + 90;

  logic        clk;
  logic        rst_i;
  int          cycle_count;

  id_dec_t     id_dec;
  stage_pipe_t id_ex_pipe;
  stage_pipe_t ex_wb_pipe;
  logic        wb_ready;
  ctrl_byp_t   ctrl_byp;

  controller_bypass i_dut (
    .id_dec_i     (id_dec),
    .id_ex_pipe_i (id_ex_pipe),
    .ex_wb_pipe_i (ex_wb_pipe),
    .wb_ready_i   (wb_ready),
    .ctrl_byp_o   (ctrl_byp)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Clock and timeout
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    clk = 1'b0;
  end

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
      $display("*** TEST FAILED ***");
      $fatal(1);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////

  // A valid stage that writes this address, with x0 never counting
  function automatic logic writes_reg(input stage_pipe_t s, input rf_addr_t addr);
    return s.instr_valid && s.rf_we && (s.rf_waddr == addr) && (addr != '0);
  endfunction

  // Explicit CSR write, or mret which writes mstatus
  function automatic logic csr_write_pending(input stage_pipe_t s);
    return s.instr_valid && (s.csr_en || (s.sys_en && s.sys_mret_insn));
  endfunction

  function automatic ctrl_byp_t expected_ctrl(input id_dec_t d, input stage_pipe_t ex,
                                              input stage_pipe_t wb, input logic rdy);
    ctrl_byp_t  e;
    logic [1:0] ex_op;
    logic [1:0] wb_op;
    logic       ex_jr;
    logic       wb_jr;
    logic       id_csr;
    e = '0;

    // Operand hits need the read enable, the jump-register hit does not
    ex_op[0] = writes_reg(ex, d.rf_raddr[0]) && d.rf_re[0];
    ex_op[1] = writes_reg(ex, d.rf_raddr[1]) && d.rf_re[1];
    wb_op[0] = writes_reg(wb, d.rf_raddr[0]) && d.rf_re[0];
    wb_op[1] = writes_reg(wb, d.rf_raddr[1]) && d.rf_re[1];
    ex_jr    = writes_reg(ex, d.rf_raddr[0]);
    wb_jr    = writes_reg(wb, d.rf_raddr[0]);

    // EX is newer than WB and takes priority
    if (ex_op[0]) e.fwd.operand_a_fw_mux_sel = SEL_FW_EX;
    else if (wb_op[0]) e.fwd.operand_a_fw_mux_sel = SEL_FW_WB;
    else e.fwd.operand_a_fw_mux_sel = SEL_REGFILE;

    if (ex_op[1]) e.fwd.operand_b_fw_mux_sel = SEL_FW_EX;
    else if (wb_op[1]) e.fwd.operand_b_fw_mux_sel = SEL_FW_WB;
    else e.fwd.operand_b_fw_mux_sel = SEL_REGFILE;

    e.fwd.jalr_fw_mux_sel = wb_jr ? SELJ_FW_WB : SELJ_REGFILE;

    e.stall.load_stall  = (ex.lsu_en && (|ex_op)) || (!rdy && (|wb_op));
    e.stall.jalr_stall  = d.instr_valid && d.alu_jmpr && (ex_jr || (wb.lsu_en && wb_jr));
    id_csr              = d.instr_valid && (d.csr_en || d.sys_mret || d.sys_wfi);
    e.stall.csr_stall   = id_csr && (csr_write_pending(ex) || csr_write_pending(wb));
    e.stall.sleep_stall = ex.instr_valid && ex.sys_en && ex.sys_wfi_insn;
    // Deassert ignores the ID valid bit
    e.stall.deassert_we = d.bus_err || d.mpu_fault;
    return e;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus and checks
  ////////////////////////////////////////////////////////////////////////////

  // True with the given chance in percent
  function automatic logic biased_bit(input int pct);
    return ($urandom % 100) < pct;
  endfunction

  // Addresses x0 to x3 only, so stages collide with ID often
  function automatic rf_addr_t small_addr();
    return rf_addr_t'($urandom % 4);
  endfunction

  function automatic stage_pipe_t random_stage();
    stage_pipe_t s;
    s.instr_valid   = biased_bit(75);
    s.rf_we         = biased_bit(70);
    s.rf_waddr      = small_addr();
    s.lsu_en        = biased_bit(50);
    s.csr_en        = biased_bit(30);
    s.sys_en        = biased_bit(50);
    s.sys_mret_insn = biased_bit(50);
    s.sys_wfi_insn  = biased_bit(50);
    return s;
  endfunction

  task automatic apply_random_vector();
    id_dec.instr_valid = biased_bit(75);
    // Faults are kept rarer so deassert_we toggles both ways
    id_dec.bus_err     = biased_bit(15);
    id_dec.mpu_fault   = biased_bit(15);
    id_dec.rf_re[0]    = biased_bit(75);
    id_dec.rf_re[1]    = biased_bit(75);
    id_dec.rf_raddr[0] = small_addr();
    id_dec.rf_raddr[1] = small_addr();
    id_dec.alu_jmpr    = biased_bit(50);
    id_dec.csr_en      = biased_bit(40);
    id_dec.sys_mret    = biased_bit(30);
    id_dec.sys_wfi     = biased_bit(30);
    id_ex_pipe         = random_stage();
    ex_wb_pipe         = random_stage();
    wb_ready           = biased_bit(50);
  endtask

  task automatic compare_field(input string name, input logic [1:0] actual,
                               input logic [1:0] expected);
    if (actual !== expected) begin
      $display("[ERROR] %0t: %s is %0d, expected %0d", $time, name, actual, expected);
      $display("*** TEST FAILED ***");
      $fatal(1);
    end
  endtask

  task automatic check_outputs(input ctrl_byp_t exp_out);
    compare_field("load_stall", ctrl_byp.stall.load_stall, exp_out.stall.load_stall);
    compare_field("jalr_stall", ctrl_byp.stall.jalr_stall, exp_out.stall.jalr_stall);
    compare_field("csr_stall", ctrl_byp.stall.csr_stall, exp_out.stall.csr_stall);
    compare_field("sleep_stall", ctrl_byp.stall.sleep_stall, exp_out.stall.sleep_stall);
    compare_field("deassert_we", ctrl_byp.stall.deassert_we, exp_out.stall.deassert_we);
    compare_field("operand_a_fw_mux_sel", ctrl_byp.fwd.operand_a_fw_mux_sel,
                  exp_out.fwd.operand_a_fw_mux_sel);
    compare_field("operand_b_fw_mux_sel", ctrl_byp.fwd.operand_b_fw_mux_sel,
                  exp_out.fwd.operand_b_fw_mux_sel);
    compare_field("jalr_fw_mux_sel", ctrl_byp.fwd.jalr_fw_mux_sel,
                  exp_out.fwd.jalr_fw_mux_sel);
  endtask

  // All inputs stay zero while reset is held, so every output must be idle
  always @(negedge clk) begin
    if (rst_i) begin
      check_outputs('0);
    end
  end

  initial begin
    cycle_count = 0;
    rst_i       = 1'b1;
    id_dec      = '0;
    id_ex_pipe  = '0;
    ex_wb_pipe  = '0;
    wb_ready    = 1'b0;
    void'($urandom(78189));

    repeat (RESET_CYCLES) @(posedge clk);
    #10 rst_i = 1'b0;

    // Idle state with every input at zero, all stalls low and all selects regfile
    @(negedge clk);
    check_outputs('0);

    for (int i = 0; i < NUM_VECTORS; i++) begin
      @(posedge clk);
      #10;
      apply_random_vector();
      @(negedge clk);
      check_outputs(expected_ctrl(id_dec, id_ex_pipe, ex_wb_pipe, wb_ready));
    end

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

//--- controller_bypass.f
+incdir+common
common/pipe_pkg.sv
common/bypass_pkg.sv
source/stage_hazard.sv
source/stall_control.sv
source/forward_select.sv
source/controller_bypass.sv
test/tb_controller_bypass.sv
